/* testbench/bot_cases.txt */
# name frame_len, then frame_len bytes in hex with usb_tlast on the last one
# err tag xfer_len dir lun blen in hex, cb_bytes data_bytes in decimal, then data bytes in hex
read10_in 25
  55 53 42 43 78 56 34 12 00 10 00 00 80 00 0a 28 00 00 00 00 10 00 00 08 00
  0 12345678 00001000 1 0 0a 10 0
bad_sig 16
  55 53 42 44 01 00 00 00 00 00 00 00 00 00 06 00
  1 00000000 00000000 0 0 00 0 0
write10_out 25
  55 53 42 43 0f 00 a5 a5 08 00 00 00 00 01 0a 2a 00 00 00 01 00 00 00 01 00
  0 a5a5000f 00000008 0 1 0a 10 8 de ad be ef 01 02 03 04
bad_flags 16
  55 53 42 43 02 00 00 00 00 00 00 00 81 00 06 00
  1 00000000 00000000 0 0 00 0 0
tur_lun2 21
  55 53 42 43 01 00 00 00 00 00 00 00 00 02 06 00 00 00 00 00 00
  0 00000001 00000000 0 2 06 6 0
bad_lun 16
  55 53 42 43 03 00 00 00 00 00 00 00 00 10 06 00
  1 00000000 00000000 0 0 00 0 0
inquiry 21
  55 53 42 43 ef be ad de 24 00 00 00 80 00 06 12 00 00 00 24 00
  0 deadbeef 00000024 1 0 06 6 0
blen_zero 16
  55 53 42 43 04 00 00 00 00 00 00 00 00 00 00 00
  1 00000000 00000000 0 0 00 0 0
max_cb 31
  55 53 42 43 0d f0 ad 0b 03 00 00 00 00 0f 10 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
  0 0badf00d 00000003 0 f 10 16 3 11 22 33
blen_17 16
  55 53 42 43 05 00 00 00 00 00 00 00 00 00 11 00
  1 00000000 00000000 0 0 00 0 0
min_cb 17
  aa 55 53 42 43 21 43 65 87 00 02 00 00 80 03 01 00
  0 87654321 00000200 1 3 01 1 0

/* filelist.f */
verilog/bot_pkg.sv
verilog/stream_skid.sv
verilog/cbw_parser.sv
verilog/bot_csr.sv
verilog/bot_top.sv
testbench/bot_tb.sv

/* Bender.yml */
package:
  name: usb_bot_parser

sources:
  # RTL
  - files:
      - verilog/bot_pkg.sv
      - verilog/stream_skid.sv
      - verilog/cbw_parser.sv
      - verilog/bot_csr.sv
      - verilog/bot_top.sv
  # Testbench
  - target: test
    files:
      - testbench/bot_tb.sv

/* testbench/bot_tb.sv */
`timescale 1ns/1ps

module bot_tb;

  import bot_pkg::*;

  localparam int clock_period = 100;
  localparam int max_cases    = 32;
  localparam int max_bytes    = 48;

  logic        clock;
  logic        reset;
  logic        usb_tvalid;
  logic        usb_tready;
  logic        usb_tlast;
  logic [7:0]  usb_tdata;
  logic        cb_tvalid;
  logic        cb_tready;
  logic        cb_tlast;
  logic [7:0]  cb_tdata;
  logic        scsi_busy;
  logic        scsi_done;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  // Case table filled from the cases file
  string       case_name  [max_cases];
  int          frame_len  [max_cases];
  logic [7:0]  frame_mem  [max_cases][max_bytes];
  logic        exp_err    [max_cases];
  logic [31:0] exp_tag    [max_cases];
  logic [31:0] exp_len    [max_cases];
  logic        exp_dir    [max_cases];
  logic [3:0]  exp_lun    [max_cases];
  logic [4:0]  exp_blen   [max_cases];
  int          cb_count   [max_cases];
  int          data_count [max_cases];
  logic [7:0]  data_mem   [max_cases][max_bytes];
  int          num_cases;
  int          total_bytes;
  bit          cases_loaded;

  // Bytes seen on the command-block stream
  logic [7:0]  rx_data[$];
  logic        rx_last[$];
  logic [31:0] lfsr_state;
  logic [31:0] ctrl_rd;
  int          error_count;

  bot_top #(
    .stream_width_p (data_width)
  ) dut (
    .clock        (clock),
    .reset        (reset),
    .usb_tvalid_i (usb_tvalid),
    .usb_tready_o (usb_tready),
    .usb_tlast_i  (usb_tlast),
    .usb_tdata_i  (usb_tdata),
    .cb_tvalid_o  (cb_tvalid),
    .cb_tready_i  (cb_tready),
    .cb_tlast_o   (cb_tlast),
    .cb_tdata_o   (cb_tdata),
    .scsi_busy_i  (scsi_busy),
    .scsi_done_i  (scsi_done),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_adr_i     (wb_adr),
    .wb_dat_i     (wb_dat_w),
    .wb_dat_o     (wb_dat_r),
    .wb_ack_o     (wb_ack)
  );

  always #(clock_period / 2) clock = ~clock;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h80200003;
    end
    return next;
  endfunction

  // Random back-pressure on the command-block stream
  always @(posedge clock) begin
    #1;
    cb_tready  = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
  end

  always @(negedge clock) begin
    if (!reset && cb_tvalid && cb_tready) begin
      rx_data.push_back(cb_tdata);
      rx_last.push_back(cb_tlast);
    end
  end

  task automatic check_value(input string name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("error %s %s: expected %h, actual %h", name, field, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic load_cases();
    int    fd;
    int    code;
    int    value;
    int    idx;
    string token;
    string rest;
    idx = 0;
    fd  = $fopen("testbench/bot_cases.txt", "r");
    if (fd != 0) begin
      while (idx < max_cases && $fscanf(fd, "%s", token) == 1) begin
        if (token.len() > 0 && token[0] == "#") begin
          code = $fgets(rest, fd);
        end else begin
          case_name[idx] = token;
          code = $fscanf(fd, "%d", value);
          frame_len[idx] = value;
          for (int i = 0; i < frame_len[idx]; i++) begin
            code = $fscanf(fd, "%h", value);
            frame_mem[idx][i] = value[7:0];
          end
          code = $fscanf(fd, "%h", value);
          exp_err[idx] = value[0];
          code = $fscanf(fd, "%h", value);
          exp_tag[idx] = value;
          code = $fscanf(fd, "%h", value);
          exp_len[idx] = value;
          code = $fscanf(fd, "%h", value);
          exp_dir[idx] = value[0];
          code = $fscanf(fd, "%h", value);
          exp_lun[idx] = value[3:0];
          code = $fscanf(fd, "%h", value);
          exp_blen[idx] = value[4:0];
          code = $fscanf(fd, "%d", value);
          cb_count[idx] = value;
          code = $fscanf(fd, "%d", value);
          data_count[idx] = value;
          for (int i = 0; i < data_count[idx]; i++) begin
            code = $fscanf(fd, "%h", value);
            data_mem[idx][i] = value[7:0];
          end
          total_bytes += frame_len[idx] + data_count[idx];
          idx++;
        end
      end
      $fclose(fd);
    end
    num_cases = idx;
  endtask

  // One Wishbone classic single cycle, ends one cycle after ack
  task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    @(posedge clock);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clock);
    while (!wb_ack) @(negedge clock);
    rdata = wb_dat_r;
    @(posedge clock);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic reg_read(input logic [2:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'd0, data);
  endtask

  task automatic reg_write(input logic [2:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  // Expects to start 1 ns after a rising edge and returns at the same point
  task automatic send_byte(input logic [7:0] value, input logic last);
    usb_tvalid = 1'b1;
    usb_tdata  = value;
    usb_tlast  = last;
    @(negedge clock);
    while (!usb_tready) @(negedge clock);
    @(posedge clock);
    #1;
    usb_tvalid = 1'b0;
    usb_tlast  = 1'b0;
  endtask

  task automatic wait_rx(input int count);
    while (rx_data.size() < count) @(posedge clock);
  endtask

  task automatic pulse_done();
    @(posedge clock);
    #1;
    scsi_done = 1'b1;
    @(posedge clock);
    #1;
    scsi_done = 1'b0;
  endtask

  task automatic check_reset_state();
    logic [31:0] rd;
    @(negedge clock);
    check_value("reset", "usb_tready_o", 32'd0, usb_tready);
    check_value("reset", "cb_tvalid_o", 32'd0, cb_tvalid);
    check_value("reset", "wb_ack_o", 32'd0, wb_ack);
    reg_read(csr_addr_ctrl, rd);
    check_value("reset", "ctrl", 32'd0, rd);
    reg_read(csr_addr_status, rd);
    check_value("reset", "status", 32'd0, rd[status_error_bit:status_valid_bit]);
  endtask

  task automatic run_case(input int idx);
    logic [31:0] rd;
    int          first;
    int          total;
    string       name;
    name  = case_name[idx];
    total = cb_count[idx] + data_count[idx];
    first = frame_len[idx] - cb_count[idx];
    rx_data.delete();
    rx_last.delete();
    @(posedge clock);
    #1;
    for (int i = 0; i < frame_len[idx]; i++) begin
      send_byte(frame_mem[idx][i], i == frame_len[idx] - 1);
    end
    if (!exp_err[idx]) begin
      wait_rx(cb_count[idx]);
      // Host-to-device data follows the command block on the same path
      if (!exp_dir[idx]) begin
        @(posedge clock);
        #1;
        for (int i = 0; i < data_count[idx]; i++) begin
          send_byte(data_mem[idx][i], i == data_count[idx] - 1);
        end
        wait_rx(total);
      end
      pulse_done();
    end
    reg_read(csr_addr_status, rd);
    check_value(name, "status valid", !exp_err[idx], rd[status_valid_bit]);
    check_value(name, "status error", exp_err[idx], rd[status_error_bit]);
    if (!exp_err[idx]) begin
      check_value(name, "status dir", exp_dir[idx], rd[status_dir_bit]);
      reg_read(csr_addr_tag, rd);
      check_value(name, "tag", exp_tag[idx], rd);
      reg_read(csr_addr_len, rd);
      check_value(name, "length", exp_len[idx], rd);
      reg_read(csr_addr_info, rd);
      check_value(name, "lun", exp_lun[idx], rd[info_lun_lsb +: lun_width]);
      check_value(name, "cb length", exp_blen[idx], rd[info_blen_lsb +: blen_width]);
      reg_write(csr_addr_ctrl, (32'd1 << ctrl_enable_bit) | (32'd1 << ctrl_ack_bit));
      reg_read(csr_addr_status, rd);
      check_value(name, "valid after ack", 32'd0, rd[status_valid_bit]);
    end else begin
      reg_write(csr_addr_status, 32'd1 << status_error_bit);
      reg_read(csr_addr_status, rd);
      check_value(name, "error after clear", 32'd0, rd[status_error_bit]);
    end
    check_value(name, "forwarded count", total, rx_data.size());
    for (int i = 0; i < total && i < rx_data.size(); i++) begin
      if (i < cb_count[idx]) begin
        check_value(name, $sformatf("cb byte %0d", i), frame_mem[idx][first + i], rx_data[i]);
        check_value(name, $sformatf("cb last %0d", i), i == cb_count[idx] - 1, rx_last[i]);
      end else begin
        check_value(name, $sformatf("data byte %0d", i), data_mem[idx][i - cb_count[idx]],
                    rx_data[i]);
        check_value(name, $sformatf("data last %0d", i), i == total - 1, rx_last[i]);
      end
    end
  endtask

  // Ready must stay low while disabled or while the SCSI side is busy
  task automatic check_gating();
    logic [31:0] tag_before;
    logic [31:0] rd;
    reg_read(csr_addr_tag, tag_before);
    reg_write(csr_addr_ctrl, 32'd0);
    @(posedge clock);
    #1;
    usb_tvalid = 1'b1;
    usb_tdata  = cbw_signature[0];
    usb_tlast  = 1'b0;
    repeat (8) begin
      @(negedge clock);
      check_value("gating_disabled", "usb_tready_o", 32'd0, usb_tready);
    end
    @(posedge clock);
    #1;
    usb_tvalid = 1'b0;
    scsi_busy  = 1'b1;
    reg_write(csr_addr_ctrl, 32'd1 << ctrl_enable_bit);
    usb_tvalid = 1'b1;
    repeat (8) begin
      @(negedge clock);
      check_value("gating_busy", "usb_tready_o", 32'd0, usb_tready);
    end
    @(posedge clock);
    #1;
    usb_tvalid = 1'b0;
    scsi_busy  = 1'b0;
    reg_read(csr_addr_status, rd);
    check_value("gating", "status", 32'd0, rd[status_error_bit:status_valid_bit]);
    reg_read(csr_addr_tag, rd);
    check_value("gating", "tag", tag_before, rd);
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    usb_tvalid   = 1'b0;
    usb_tlast    = 1'b0;
    usb_tdata    = 8'd0;
    cb_tready    = 1'b0;
    scsi_busy    = 1'b0;
    scsi_done    = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = 3'd0;
    wb_dat_w     = 32'd0;
    lfsr_state   = 32'hb5ab;
    error_count  = 0;
    total_bytes  = 0;
    num_cases    = 0;
    cases_loaded = 1'b0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    if (num_cases == 0) begin
      $display("No test cases could be read from testbench/bot_cases.txt");
      error_count++;
    end else begin
      check_reset_state();
      reg_write(csr_addr_ctrl, 32'd1 << ctrl_enable_bit);
      reg_read(csr_addr_ctrl, ctrl_rd);
      check_value("enable", "ctrl", 32'd1 << ctrl_enable_bit, ctrl_rd);
      for (int i = 0; i < num_cases; i++) begin
        run_case(i);
      end
      check_gating();
    end
    finish_run();
  end

  initial begin : watchdog
    int limit;
    wait (cases_loaded);
    if (num_cases > 0) begin
      limit = total_bytes * 4 + num_cases * 200;
      repeat (limit) @(posedge clock);
      $display("The run timed out after %0d clock cycles", limit);
      error_count++;
      finish_run();
    end
  end

endmodule

/* verilog/bot_top.sv */
`timescale 1ns/1ps

module bot_top #(
  parameter int stream_width_p = bot_pkg::data_width
) (
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      usb_tvalid_i,
  output logic                      usb_tready_o,
  input  logic                      usb_tlast_i,
  input  logic [stream_width_p-1:0] usb_tdata_i,

  output logic                      cb_tvalid_o,
  input  logic                      cb_tready_i,
  output logic                      cb_tlast_o,
  output logic [stream_width_p-1:0] cb_tdata_o,

  input  logic                      scsi_busy_i,
  input  logic                      scsi_done_i,

  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [2:0]                wb_adr_i,
  input  logic [31:0]               wb_dat_i,
  output logic [31:0]               wb_dat_o,
  output logic                      wb_ack_o
);

  logic                            parse_enable;
  logic                            cbw_ack;
  logic                            cbw_vld;
  logic                            cbw_dir;
  logic [bot_pkg::tag_width-1:0]   cbw_tag;
  logic [bot_pkg::len_width-1:0]   cbw_len;
  logic [bot_pkg::lun_width-1:0]   cbw_lun;
  logic [bot_pkg::blen_width-1:0]  cbw_blen;
  logic                            parse_error;
  logic                            skid_flush;
  logic                            skid_tvalid;
  logic                            skid_tready;

  cbw_parser u_parser (
    .clock         (clock),
    .reset         (reset),
    .enable_i      (parse_enable),
    .scsi_busy_i   (scsi_busy_i),
    .scsi_done_i   (scsi_done_i),
    .usb_tvalid_i  (usb_tvalid_i),
    .usb_tready_o  (usb_tready_o),
    .usb_tlast_i   (usb_tlast_i),
    .usb_tdata_i   (usb_tdata_i),
    .cbw_ack_i     (cbw_ack),
    .cbw_vld_o     (cbw_vld),
    .cbw_dir_o     (cbw_dir),
    .cbw_tag_o     (cbw_tag),
    .cbw_len_o     (cbw_len),
    .cbw_lun_o     (cbw_lun),
    .cbw_blen_o    (cbw_blen),
    .error_o       (parse_error),
    .skid_flush_o  (skid_flush),
    .skid_tvalid_o (skid_tvalid),
    .skid_tready_i (skid_tready)
  );

  // Command block and host-to-device data both leave through here
  stream_skid #(
    .width_p (stream_width_p)
  ) u_skid (
    .clock      (clock),
    .reset      (reset),
    .flush_i    (skid_flush),
    .s_tvalid_i (skid_tvalid),
    .s_tready_o (skid_tready),
    .s_tlast_i  (usb_tlast_i),
    .s_tdata_i  (usb_tdata_i),
    .m_tvalid_o (cb_tvalid_o),
    .m_tready_i (cb_tready_i),
    .m_tlast_o  (cb_tlast_o),
    .m_tdata_o  (cb_tdata_o)
  );

  bot_csr u_csr (
    .clock          (clock),
    .reset          (reset),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .cbw_vld_i      (cbw_vld),
    .cbw_dir_i      (cbw_dir),
    .cbw_tag_i      (cbw_tag),
    .cbw_len_i      (cbw_len),
    .cbw_lun_i      (cbw_lun),
    .cbw_blen_i     (cbw_blen),
    .error_i        (parse_error),
    .parse_enable_o (parse_enable),
    .cbw_ack_o      (cbw_ack)
  );

endmodule

/* verilog/bot_csr.sv */
`timescale 1ns/1ps

module bot_csr (
  input  logic                            clock,
  input  logic                            reset,

  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [2:0]                      wb_adr_i,
  input  logic [31:0]                     wb_dat_i,
  output logic [31:0]                     wb_dat_o,
  output logic                            wb_ack_o,

  input  logic                            cbw_vld_i,
  input  logic                            cbw_dir_i,
  input  logic [bot_pkg::tag_width-1:0]   cbw_tag_i,
  input  logic [bot_pkg::len_width-1:0]   cbw_len_i,
  input  logic [bot_pkg::lun_width-1:0]   cbw_lun_i,
  input  logic [bot_pkg::blen_width-1:0]  cbw_blen_i,
  input  logic                            error_i,

  output logic                            parse_enable_o,
  output logic                            cbw_ack_o
);

  import bot_pkg::*;

  logic                  access;
  logic                  wr_en;
  logic                  err_q;
  logic                  vld_q;
  logic                  dir_q;
  logic [tag_width-1:0]  tag_q;
  logic [len_width-1:0]  len_q;
  logic [lun_width-1:0]  lun_q;
  logic [blen_width-1:0] blen_q;
  logic [31:0]           ctrl_w;
  logic [31:0]           status_w;
  logic [31:0]           info_w;

  // New cycle seen, ack is not yet high
  assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_en  = access && wb_we_i;

  always_comb begin
    ctrl_w   = '0;
    status_w = '0;
    info_w   = '0;
    ctrl_w[ctrl_enable_bit]    = parse_enable_o;
    status_w[status_valid_bit] = cbw_vld_i;
    status_w[status_error_bit] = err_q;
    status_w[status_dir_bit]   = dir_q;
    info_w[info_lun_lsb +: lun_width]   = lun_q;
    info_w[info_blen_lsb +: blen_width] = blen_q;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_ack_o       <= 1'b0;
      parse_enable_o <= 1'b0;
      cbw_ack_o      <= 1'b0;
      err_q          <= 1'b0;
      vld_q          <= 1'b0;
    end else begin
      wb_ack_o  <= access;
      vld_q     <= cbw_vld_i;
      cbw_ack_o <= wr_en && (wb_adr_i == csr_addr_ctrl) && wb_dat_i[ctrl_ack_bit];
      if (wr_en && wb_adr_i == csr_addr_ctrl) begin
        parse_enable_o <= wb_dat_i[ctrl_enable_bit];
      end
      // A new error wins over a clear in the same cycle
      if (error_i) begin
        err_q <= 1'b1;
      end else if (wr_en && wb_adr_i == csr_addr_status && wb_dat_i[status_error_bit]) begin
        err_q <= 1'b0;
      end
    end
  end

  // Snapshot of the decoded CBW when it becomes valid
  always_ff @(posedge clock) begin
    if (cbw_vld_i && !vld_q) begin
      dir_q  <= cbw_dir_i;
      tag_q  <= cbw_tag_i;
      len_q  <= cbw_len_i;
      lun_q  <= cbw_lun_i;
      blen_q <= cbw_blen_i;
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      case (wb_adr_i)
        csr_addr_ctrl:   wb_dat_o <= ctrl_w;
        csr_addr_status: wb_dat_o <= status_w;
        csr_addr_tag:    wb_dat_o <= tag_q;
        csr_addr_len:    wb_dat_o <= len_q;
        csr_addr_info:   wb_dat_o <= info_w;
        default:         wb_dat_o <= '0;
      endcase
    end
  end

  a_ack_single: assert property (
    @(posedge clock) disable iff (reset)
    wb_ack_o |=> !wb_ack_o
  ) else $error("Wishbone ack held for two cycles");

endmodule

/* verilog/cbw_parser.sv */
`timescale 1ns/1ps

module cbw_parser (
  input  logic                            clock,
  input  logic                            reset,

  input  logic                            enable_i,
  input  logic                            scsi_busy_i,
  input  logic                            scsi_done_i,

  input  logic                            usb_tvalid_i,
  output logic                            usb_tready_o,
  input  logic                            usb_tlast_i,
  input  logic [bot_pkg::data_width-1:0]  usb_tdata_i,

  input  logic                            cbw_ack_i,
  output logic                            cbw_vld_o,
  output logic                            cbw_dir_o,
  output logic [bot_pkg::tag_width-1:0]   cbw_tag_o,
  output logic [bot_pkg::len_width-1:0]   cbw_len_o,
  output logic [bot_pkg::lun_width-1:0]   cbw_lun_o,
  output logic [bot_pkg::blen_width-1:0]  cbw_blen_o,
  output logic                            error_o,

  output logic                            skid_flush_o,
  output logic                            skid_tvalid_o,
  input  logic                            skid_tready_i
);

  import bot_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_header,
    st_cmd,
    st_data,
    st_wait_done,
    st_discard
  } state_t;

  state_t     state;
  logic [3:0] hdr_idx;
  logic       hdr_bad;
  logic       own_ready;
  logic       path_open;
  logic       usb_fire;

  // Skid path carries the command block and host-to-device data
  assign path_open     = (state == st_cmd) || (state == st_data);
  assign own_ready     = ((state == st_idle) && enable_i && !scsi_busy_i) ||
                         (state == st_header) || (state == st_discard);
  assign usb_tready_o  = path_open ? skid_tready_i : own_ready;
  assign usb_fire      = usb_tvalid_i && usb_tready_o;
  assign skid_tvalid_o = path_open && usb_tvalid_i;

  // Flush stays low while waiting on the SCSI side so the command block drains
  assign skid_flush_o  = !(path_open || (state == st_wait_done));

  // Per-byte header checks, byte 0 is matched in idle
  always_comb begin
    hdr_bad = 1'b0;
    case (hdr_idx)
      4'd1, 4'd2, 4'd3: hdr_bad = usb_tdata_i != cbw_signature[hdr_idx[1:0]];
      4'd12:            hdr_bad = usb_tdata_i[6:0] != 7'd0;
      4'd13:            hdr_bad = usb_tdata_i[7:4] != 4'd0;
      4'd14:            hdr_bad = (usb_tdata_i == '0) || (usb_tdata_i > cb_len_max);
      default:          hdr_bad = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= st_idle;
      hdr_idx   <= 4'd0;
      cbw_vld_o <= 1'b0;
      error_o   <= 1'b0;
    end else begin
      error_o <= 1'b0;
      if (cbw_ack_i) begin
        cbw_vld_o <= 1'b0;
      end
      case (state)
        st_idle: begin
          hdr_idx <= 4'd1;
          // Anything but the first signature byte is dropped
          if (usb_fire && usb_tdata_i == cbw_signature[0]) begin
            state <= st_header;
          end
        end
        st_header: begin
          if (usb_fire) begin
            hdr_idx <= hdr_idx + 4'd1;
            if (hdr_bad) begin
              error_o <= 1'b1;
              state   <= usb_tlast_i ? st_idle : st_discard;
            end else if (hdr_idx == 4'd14) begin
              cbw_vld_o <= 1'b1;
              state     <= st_cmd;
            end
          end
        end
        st_cmd: begin
          if (usb_fire && usb_tlast_i) begin
            // Direction bit set means device to host
            state <= cbw_dir_o ? st_wait_done : st_data;
          end
        end
        st_data, st_wait_done: begin
          if (scsi_done_i) begin
            state <= st_idle;
          end
        end
        st_discard: begin
          if (usb_fire && usb_tlast_i) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Little-endian field capture
  always_ff @(posedge clock) begin
    if (state == st_header && usb_fire) begin
      case (hdr_idx)
        4'd4:  cbw_tag_o[7:0]   <= usb_tdata_i;
        4'd5:  cbw_tag_o[15:8]  <= usb_tdata_i;
        4'd6:  cbw_tag_o[23:16] <= usb_tdata_i;
        4'd7:  cbw_tag_o[31:24] <= usb_tdata_i;
        4'd8:  cbw_len_o[7:0]   <= usb_tdata_i;
        4'd9:  cbw_len_o[15:8]  <= usb_tdata_i;
        4'd10: cbw_len_o[23:16] <= usb_tdata_i;
        4'd11: cbw_len_o[31:24] <= usb_tdata_i;
        4'd12: cbw_dir_o        <= usb_tdata_i[7];
        4'd13: cbw_lun_o        <= usb_tdata_i[lun_width-1:0];
        4'd14: cbw_blen_o       <= usb_tdata_i[blen_width-1:0];
        default: ;
      endcase
    end
  end

  // A rejected frame never reports a decoded CBW
  a_err_no_vld: assert property (
    @(posedge clock) disable iff (reset)
    !(error_o && $rose(cbw_vld_o))
  ) else $error("error and new CBW in the same cycle");

  a_busy_gate: assert property (
    @(posedge clock) disable iff (reset)
    (state == st_idle) && scsi_busy_i |-> !usb_tready_o
  ) else $error("frame accepted while SCSI side busy");

endmodule

/* verilog/stream_skid.sv */
`timescale 1ns/1ps

module stream_skid #(
  parameter int width_p = 8
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               flush_i,

  input  logic               s_tvalid_i,
  output logic               s_tready_o,
  input  logic               s_tlast_i,
  input  logic [width_p-1:0] s_tdata_i,

  output logic               m_tvalid_o,
  input  logic               m_tready_i,
  output logic               m_tlast_o,
  output logic [width_p-1:0] m_tdata_o
);

  logic               spare_vld;
  logic               spare_last;
  logic [width_p-1:0] spare_data;
  logic               s_fire;
  logic               out_free;

  // Ready only while the spare entry is free
  assign s_tready_o = !spare_vld && !flush_i;
  assign s_fire     = s_tvalid_i && s_tready_o;
  assign out_free   = !m_tvalid_o || m_tready_i;

  always_ff @(posedge clock) begin
    if (reset || flush_i) begin
      m_tvalid_o <= 1'b0;
      spare_vld  <= 1'b0;
    end else if (out_free) begin
      // Spare drains first, input is blocked while it is full
      m_tvalid_o <= spare_vld || s_fire;
      spare_vld  <= 1'b0;
    end else if (s_fire) begin
      spare_vld <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (out_free) begin
      if (spare_vld) begin
        m_tdata_o <= spare_data;
        m_tlast_o <= spare_last;
      end else if (s_fire) begin
        m_tdata_o <= s_tdata_i;
        m_tlast_o <= s_tlast_i;
      end
    end else if (s_fire) begin
      // Byte caught in the cycle the consumer stalls
      spare_data <= s_tdata_i;
      spare_last <= s_tlast_i;
    end
  end

  // A stalled output holds its byte until taken or flushed
  a_hold_stable: assert property (
    @(posedge clock) disable iff (reset || flush_i)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o) && $stable(m_tlast_o)
  ) else $error("skid output changed while stalled");

endmodule

/* verilog/bot_pkg.sv */
package bot_pkg;

  // Stream width for the USB and command-block byte streams
  localparam int data_width = 8;

  // CBW signature "USBC" in arrival order, byte 0 first
  localparam logic [3:0][7:0] cbw_signature = {8'h43, 8'h42, 8'h53, 8'h55};

  // Largest legal command-block length
  localparam logic [4:0] cb_len_max = 5'd16;

  // Decoded field widths
  localparam int tag_width  = 32;
  localparam int len_width  = 32;
  localparam int lun_width  = 4;
  localparam int blen_width = 5;

  // Register map, Wishbone word addresses
  localparam logic [2:0] csr_addr_ctrl   = 3'd0;
  localparam logic [2:0] csr_addr_status = 3'd1;
  localparam logic [2:0] csr_addr_tag    = 3'd2;
  localparam logic [2:0] csr_addr_len    = 3'd3;
  localparam logic [2:0] csr_addr_info   = 3'd4;

  // Control register fields
  localparam int ctrl_enable_bit = 0;
  localparam int ctrl_ack_bit    = 1;

  // Status register fields
  localparam int status_valid_bit = 0;
  localparam int status_error_bit = 1;
  localparam int status_dir_bit   = 2;

  // Info register layout
  localparam int info_lun_lsb  = 0;
  localparam int info_blen_lsb = 8;

endpackage
